/* noc_defines.svh */
`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// flit and AXI-lite widths
`define NOC_DATA_WIDTH   64
`define AXIL_ADDR_WIDTH  40
`define AXIL_DATA_WIDTH  64
`define AXIL_STRB_WIDTH  8

// header field widths
`define NOC_CHIPID_WIDTH 14
`define NOC_XY_WIDTH     8
`define NOC_FBITS_WIDTH  4
`define NOC_LEN_WIDTH    8

// wake-up counter, top bit sets after 2**(bits-1) cycles
`define WAKE_CNT_BITS    5

// home node that receives every request
`define NOC_DEST_CHIPID  14'd0
`define NOC_DEST_X       8'd0
`define NOC_DEST_Y       8'd0
`define NOC_DEST_FBITS   4'd0

`endif

/* noc_pkg.sv */
`include "noc_defines.svh"

package noc_pkg;

  // message types
  // requests sit low, responses have bit 7 set
  typedef enum logic [7:0] {
    NOC_LOAD_REQ   = 8'h01,
    NOC_STORE_REQ  = 8'h02,
    NOC_LOAD_ACK   = 8'h81,
    NOC_LOAD_NACK  = 8'h82,
    NOC_STORE_ACK  = 8'h83,
    NOC_STORE_NACK = 8'h84
  } noc_msg_e;

  // header flit, msb first
  typedef struct packed {
    logic [`NOC_CHIPID_WIDTH-1:0] dest_chipid;
    logic [`NOC_XY_WIDTH-1:0]     dest_x;
    logic [`NOC_XY_WIDTH-1:0]     dest_y;
    logic [`NOC_FBITS_WIDTH-1:0]  dest_fbits;
    // flits after the header
    logic [`NOC_LEN_WIDTH-1:0]    payload_len;
    noc_msg_e                     msg_type;
    // byte enables, stores only
    logic [`AXIL_STRB_WIDTH-1:0]  strb;
    logic [5:0]                   reserved;
  } noc_header_t;

  // request header toward the fixed home node
  function automatic noc_header_t noc_make_hdr(noc_msg_e msg,
                                               logic [`NOC_LEN_WIDTH-1:0] len,
                                               logic [`AXIL_STRB_WIDTH-1:0] strb);
    noc_header_t hdr;
    hdr.dest_chipid = `NOC_DEST_CHIPID;
    hdr.dest_x      = `NOC_DEST_X;
    hdr.dest_y      = `NOC_DEST_Y;
    hdr.dest_fbits  = `NOC_DEST_FBITS;
    hdr.payload_len = len;
    hdr.msg_type    = msg;
    hdr.strb        = strb;
    hdr.reserved    = '0;
    return hdr;
  endfunction

  // store-class messages go to the write side
  function automatic logic noc_is_store(noc_msg_e msg);
    return (msg == NOC_STORE_REQ) || (msg == NOC_STORE_ACK) || (msg == NOC_STORE_NACK);
  endfunction

endpackage

/* axil_pkg.sv */
package axil_pkg;

  // AXI-lite response codes in use
  typedef enum logic [1:0] {
    AXIL_OKAY   = 2'b00,
    AXIL_SLVERR = 2'b10
  } axil_resp_e;

  // read unit FSM
  typedef enum logic [2:0] {
    RD_IDLE,
    RD_HDR,
    RD_ADDR,
    RD_WAIT,
    RD_RESP
  } read_state_e;

  // write unit FSM
  typedef enum logic [2:0] {
    WR_IDLE,
    WR_HDR,
    WR_ADDR,
    WR_DATA,
    WR_WAIT,
    WR_RESP
  } write_state_e;

endpackage

/* noc_flit_if.sv */
`timescale 1ns/1ps
`include "noc_defines.svh"

// one flit stream with valid/ready handshake
interface noc_flit_if;

  logic                       valid;
  logic [`NOC_DATA_WIDTH-1:0] data;
  // marks final flit of a packet
  logic                       last;
  logic                       ready;

  // packet producer
  modport src (
    output valid,
    output data,
    output last,
    input  ready
  );

  // packet consumer
  modport snk (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

/* tile_reset_seq.sv */
`timescale 1ns/1ps
`include "noc_defines.svh"

module tile_reset_seq (
  input  logic clk_i,
  input  logic reset_l,
  output logic tile_rst_l_o
);

  logic [`WAKE_CNT_BITS-1:0] wake_cnt_q;
  logic                      wake_done;
  logic                      rst_pre_l;
  logic [1:0]                sync_q;

  // top bit set means the wait is over
  assign wake_done = wake_cnt_q[`WAKE_CNT_BITS-1];

  // count up from reset, hold once done
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      wake_cnt_q <= '0;
    end else if (!wake_done) begin
      wake_cnt_q <= wake_cnt_q + `WAKE_CNT_BITS'(1);
    end
  end

  // gated with the raw reset so assertion is immediate
  assign rst_pre_l = wake_done & reset_l;

  // two-flop synchronizer on the release edge
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], rst_pre_l};
    end
  end

  assign tile_rst_l_o = sync_q[1];

endmodule

/* axil_read_unit.sv */
`timescale 1ns/1ps
`include "noc_defines.svh"

module axil_read_unit
  import noc_pkg::*;
  import axil_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        reset_l,
  input  logic [`AXIL_ADDR_WIDTH-1:0] ar_addr_i,
  input  logic                        ar_valid_i,
  output logic                        ar_ready_o,
  output logic [`AXIL_DATA_WIDTH-1:0] r_data_o,
  output axil_resp_e                  r_resp_o,
  output logic                        r_valid_o,
  input  logic                        r_ready_i,
  noc_flit_if.src                     tx,
  noc_flit_if.snk                     rx
);

  read_state_e                 state_q, state_d;
  logic [`AXIL_ADDR_WIDTH-1:0] addr_q;
  logic [`AXIL_DATA_WIDTH-1:0] data_q;
  axil_resp_e                  resp_q;
  // header of the response already taken
  logic                        hdr_seen_q;
  noc_header_t                 rx_hdr;
  logic                        rx_fire;

  assign rx_hdr  = rx.data;
  assign rx_fire = rx.valid & rx.ready;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      RD_IDLE: if (ar_valid_i) begin
        state_d = RD_HDR;
      end
      RD_HDR: if (tx.ready) begin
        state_d = RD_ADDR;
      end
      RD_ADDR: if (tx.ready) begin
        state_d = RD_WAIT;
      end
      // leave on the final response flit
      RD_WAIT: if (rx_fire && rx.last) begin
        state_d = RD_RESP;
      end
      RD_RESP: if (r_ready_i) begin
        state_d = RD_IDLE;
      end
      default: state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      state_q    <= RD_IDLE;
      hdr_seen_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (rx_fire) begin
        hdr_seen_q <= !rx.last;
      end
    end
  end

  // address and response payload
  always_ff @(posedge clk_i) begin
    if (ar_valid_i && ar_ready_o) begin
      addr_q <= ar_addr_i;
    end
    if (rx_fire) begin
      if (!hdr_seen_q) begin
        // header decides the response code
        resp_q <= (rx_hdr.msg_type == NOC_LOAD_ACK) ? AXIL_OKAY : AXIL_SLVERR;
        data_q <= '0;
      end else if (resp_q == AXIL_OKAY) begin
        // nack data is dropped, stays zero
        data_q <= rx.data;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////////////////////

  assign ar_ready_o = (state_q == RD_IDLE);

  // load packet is header then address
  assign tx.valid = (state_q == RD_HDR) || (state_q == RD_ADDR);
  assign tx.last  = (state_q == RD_ADDR);
  assign tx.data  = (state_q == RD_HDR) ?
                    noc_make_hdr(NOC_LOAD_REQ, `NOC_LEN_WIDTH'(1), '0) :
                    {{(`NOC_DATA_WIDTH-`AXIL_ADDR_WIDTH){1'b0}}, addr_q};

  assign rx.ready = (state_q == RD_WAIT);

  assign r_valid_o = (state_q == RD_RESP);
  assign r_data_o  = data_q;
  assign r_resp_o  = resp_q;

endmodule

/* axil_write_unit.sv */
`timescale 1ns/1ps
`include "noc_defines.svh"

module axil_write_unit
  import noc_pkg::*;
  import axil_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        reset_l,
  input  logic [`AXIL_ADDR_WIDTH-1:0] aw_addr_i,
  input  logic                        aw_valid_i,
  output logic                        aw_ready_o,
  input  logic [`AXIL_DATA_WIDTH-1:0] w_data_i,
  input  logic [`AXIL_STRB_WIDTH-1:0] w_strb_i,
  input  logic                        w_valid_i,
  output logic                        w_ready_o,
  output axil_resp_e                  b_resp_o,
  output logic                        b_valid_o,
  input  logic                        b_ready_i,
  noc_flit_if.src                     tx,
  noc_flit_if.snk                     rx
);

  write_state_e                state_q, state_d;
  logic [`AXIL_ADDR_WIDTH-1:0] addr_q;
  logic [`AXIL_DATA_WIDTH-1:0] data_q;
  logic [`AXIL_STRB_WIDTH-1:0] strb_q;
  axil_resp_e                  resp_q;
  // one channel in, other still pending
  logic                        aw_have_q;
  logic                        w_have_q;
  logic                        aw_fire;
  logic                        w_fire;
  logic                        aw_got;
  logic                        w_got;
  noc_header_t                 rx_hdr;
  logic                        rx_fire;

  assign aw_ready_o = (state_q == WR_IDLE) && !aw_have_q;
  assign w_ready_o  = (state_q == WR_IDLE) && !w_have_q;
  assign aw_fire    = aw_valid_i & aw_ready_o;
  assign w_fire     = w_valid_i & w_ready_o;
  // held earlier or taken this cycle
  assign aw_got     = aw_have_q | aw_fire;
  assign w_got      = w_have_q | w_fire;

  assign rx_hdr  = rx.data;
  assign rx_fire = rx.valid & rx.ready;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      WR_IDLE: if (aw_got && w_got) begin
        state_d = WR_HDR;
      end
      WR_HDR: if (tx.ready) begin
        state_d = WR_ADDR;
      end
      WR_ADDR: if (tx.ready) begin
        state_d = WR_DATA;
      end
      WR_DATA: if (tx.ready) begin
        state_d = WR_WAIT;
      end
      // store response is a lone header
      WR_WAIT: if (rx_fire && rx.last) begin
        state_d = WR_RESP;
      end
      WR_RESP: if (b_ready_i) begin
        state_d = WR_IDLE;
      end
      default: state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      state_q   <= WR_IDLE;
      aw_have_q <= 1'b0;
      w_have_q  <= 1'b0;
    end else begin
      state_q   <= state_d;
      // flags drop once both halves are in
      aw_have_q <= aw_got & ~w_got;
      w_have_q  <= w_got & ~aw_got;
    end
  end

  // request and response payload
  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      addr_q <= aw_addr_i;
    end
    if (w_fire) begin
      data_q <= w_data_i;
      strb_q <= w_strb_i;
    end
    if (rx_fire) begin
      resp_q <= (rx_hdr.msg_type == NOC_STORE_ACK) ? AXIL_OKAY : AXIL_SLVERR;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////////////////////

  // store packet is header, address, data
  always_comb begin
    tx.valid = 1'b1;
    tx.last  = 1'b0;
    case (state_q)
      WR_HDR:  tx.data = noc_make_hdr(NOC_STORE_REQ, `NOC_LEN_WIDTH'(2), strb_q);
      WR_ADDR: tx.data = {{(`NOC_DATA_WIDTH-`AXIL_ADDR_WIDTH){1'b0}}, addr_q};
      WR_DATA: begin
        tx.data = data_q;
        tx.last = 1'b1;
      end
      default: begin
        tx.data  = data_q;
        tx.valid = 1'b0;
      end
    endcase
  end

  assign rx.ready = (state_q == WR_WAIT);

  assign b_valid_o = (state_q == WR_RESP);
  assign b_resp_o  = resp_q;

endmodule

/* noc_port_arbiter.sv */
`timescale 1ns/1ps
`include "noc_defines.svh"

module noc_port_arbiter
  import noc_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       reset_l,
  noc_flit_if.snk                    rd_tx,
  noc_flit_if.snk                    wr_tx,
  noc_flit_if.src                    rd_rx,
  noc_flit_if.src                    wr_rx,
  output logic                       noc_out_valid_o,
  output logic [`NOC_DATA_WIDTH-1:0] noc_out_data_o,
  output logic                       noc_out_last_o,
  input  logic                       noc_out_ready_i,
  input  logic                       noc_in_valid_i,
  input  logic [`NOC_DATA_WIDTH-1:0] noc_in_data_i,
  output logic                       noc_in_ready_o
);

  ////////////////////////////////////////////////////////////////////////////
  // outbound
  ////////////////////////////////////////////////////////////////////////////

  // select 0 is read, 1 is write
  logic out_sel;
  logic lock_q;
  logic owner_q;
  // write side preferred when set
  logic prio_q;

  // locked grant wins, else round robin
  assign out_sel = lock_q ? owner_q : (wr_tx.valid && (!rd_tx.valid || prio_q));

  assign noc_out_valid_o = out_sel ? wr_tx.valid : rd_tx.valid;
  assign noc_out_data_o  = out_sel ? wr_tx.data  : rd_tx.data;
  assign noc_out_last_o  = out_sel ? wr_tx.last  : rd_tx.last;
  assign rd_tx.ready     = noc_out_ready_i & ~out_sel;
  assign wr_tx.ready     = noc_out_ready_i & out_sel;

  // lock as soon as a header shows, release after last
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      lock_q  <= 1'b0;
      owner_q <= 1'b0;
      prio_q  <= 1'b0;
    end else if (noc_out_valid_o) begin
      if (noc_out_ready_i && noc_out_last_o) begin
        lock_q <= 1'b0;
        prio_q <= ~out_sel;
      end else begin
        lock_q  <= 1'b1;
        owner_q <= out_sel;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // inbound
  ////////////////////////////////////////////////////////////////////////////

  noc_header_t               in_hdr;
  logic                      in_busy_q;
  logic                      in_dst_q;
  // flits still due after the current one
  logic [`NOC_LEN_WIDTH-1:0] in_cnt_q;
  logic                      in_dst;
  logic                      in_last;
  logic                      in_fire;

  assign in_hdr = noc_in_data_i;

  // header picks the unit, body follows it
  assign in_dst  = in_busy_q ? in_dst_q : noc_is_store(in_hdr.msg_type);
  assign in_last = in_busy_q ? (in_cnt_q == `NOC_LEN_WIDTH'(1)) : (in_hdr.payload_len == '0);

  assign rd_rx.valid    = noc_in_valid_i & ~in_dst;
  assign wr_rx.valid    = noc_in_valid_i & in_dst;
  assign rd_rx.data     = noc_in_data_i;
  assign wr_rx.data     = noc_in_data_i;
  assign rd_rx.last     = in_last;
  assign wr_rx.last     = in_last;
  assign noc_in_ready_o = in_dst ? wr_rx.ready : rd_rx.ready;
  assign in_fire        = noc_in_valid_i & noc_in_ready_o;

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      in_busy_q <= 1'b0;
      in_dst_q  <= 1'b0;
      in_cnt_q  <= '0;
    end else if (in_fire) begin
      in_busy_q <= !in_last;
      if (!in_busy_q) begin
        in_dst_q <= in_dst;
        in_cnt_q <= in_hdr.payload_len;
      end else begin
        in_cnt_q <= in_cnt_q - `NOC_LEN_WIDTH'(1);
      end
    end
  end

endmodule

/* noc_axil_bridge_top.sv */
`timescale 1ns/1ps
`include "noc_defines.svh"

module noc_axil_bridge_top (
  input  logic                        clk_i,
  input  logic                        reset_l,
  output logic                        tile_rst_l_o,
  // AXI-lite write address and data
  input  logic [`AXIL_ADDR_WIDTH-1:0] aw_addr_i,
  input  logic                        aw_valid_i,
  output logic                        aw_ready_o,
  input  logic [`AXIL_DATA_WIDTH-1:0] w_data_i,
  input  logic [`AXIL_STRB_WIDTH-1:0] w_strb_i,
  input  logic                        w_valid_i,
  output logic                        w_ready_o,
  // write response
  output logic [1:0]                  b_resp_o,
  output logic                        b_valid_o,
  input  logic                        b_ready_i,
  // read address and data
  input  logic [`AXIL_ADDR_WIDTH-1:0] ar_addr_i,
  input  logic                        ar_valid_i,
  output logic                        ar_ready_o,
  output logic [`AXIL_DATA_WIDTH-1:0] r_data_o,
  output logic [1:0]                  r_resp_o,
  output logic                        r_valid_o,
  input  logic                        r_ready_i,
  // NoC request side
  output logic                        noc_out_valid_o,
  output logic [`NOC_DATA_WIDTH-1:0]  noc_out_data_o,
  output logic                        noc_out_last_o,
  input  logic                        noc_out_ready_i,
  // NoC response side
  input  logic                        noc_in_valid_i,
  input  logic [`NOC_DATA_WIDTH-1:0]  noc_in_data_i,
  output logic                        noc_in_ready_o
);

  // per-unit request and response streams
  noc_flit_if rd_tx ();
  noc_flit_if wr_tx ();
  noc_flit_if rd_rx ();
  noc_flit_if wr_rx ();

  // everything below runs on the sequenced tile reset
  tile_reset_seq u_reset_seq (
    .clk_i        (clk_i),
    .reset_l      (reset_l),
    .tile_rst_l_o (tile_rst_l_o)
  );

  axil_read_unit u_read (
    .clk_i      (clk_i),
    .reset_l    (tile_rst_l_o),
    .ar_addr_i  (ar_addr_i),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp_o),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .tx         (rd_tx.src),
    .rx         (rd_rx.snk)
  );

  axil_write_unit u_write (
    .clk_i      (clk_i),
    .reset_l    (tile_rst_l_o),
    .aw_addr_i  (aw_addr_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .b_resp_o   (b_resp_o),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .tx         (wr_tx.src),
    .rx         (wr_rx.snk)
  );

  // shared NoC port
  noc_port_arbiter u_arb (
    .clk_i           (clk_i),
    .reset_l         (tile_rst_l_o),
    .rd_tx           (rd_tx.snk),
    .wr_tx           (wr_tx.snk),
    .rd_rx           (rd_rx.src),
    .wr_rx           (wr_rx.src),
    .noc_out_valid_o (noc_out_valid_o),
    .noc_out_data_o  (noc_out_data_o),
    .noc_out_last_o  (noc_out_last_o),
    .noc_out_ready_i (noc_out_ready_i),
    .noc_in_valid_i  (noc_in_valid_i),
    .noc_in_data_i   (noc_in_data_i),
    .noc_in_ready_o  (noc_in_ready_o)
  );

endmodule

/* tb_noc_mem_model.sv */
`timescale 1ns/1ps
`include "noc_defines.svh"

// home node memory on the far side of the NoC port
module tb_noc_mem_model
  import noc_pkg::*;
#(
  parameter logic [31:0] SEED = 32'h769d_4d45
) (
  input  logic                       clk_i,
  // request packets from the bridge
  input  logic                       req_valid_i,
  input  logic [`NOC_DATA_WIDTH-1:0] req_data_i,
  input  logic                       req_last_i,
  output logic                       req_ready_o,
  // response packets toward the bridge
  output logic                       rsp_valid_o,
  output logic [`NOC_DATA_WIDTH-1:0] rsp_data_o,
  input  logic                       rsp_ready_i,
  output logic                       error_o
);

  logic [63:0] mem [0:255];
  integer      seed;
  logic [63:0] hdr_flit;
  logic [63:0] addr_flit;
  logic [63:0] data_flit;
  logic        last;
  logic        is_store;
  logic        oor;
  logic [7:0]  idx;
  int          delay;
  noc_header_t req_hdr;
  noc_header_t rsp_hdr;

  ////////////////////////////////////////////////////////////////////////////
  // flit transfer helpers
  ////////////////////////////////////////////////////////////////////////////

  // one inbound flit, ready toggled at random
  task automatic take_flit(output logic [63:0] data, output logic is_last);
    logic        got;
    logic [31:0] r;
    got = 1'b0;
    while (!got) begin
      @(negedge clk_i);
      r = $random(seed);
      req_ready_o = (r[1:0] != 2'b00);
      @(posedge clk_i);
      got = req_valid_i & req_ready_o;
    end
    data    = req_data_i;
    is_last = req_last_i;
  endtask

  // one outbound flit, held until taken
  task automatic give_flit(input logic [63:0] data);
    @(negedge clk_i);
    rsp_valid_o = 1'b1;
    rsp_data_o  = data;
    do @(posedge clk_i); while (!rsp_ready_i);
  endtask

  // flag the packet error and park this process
  task automatic report_bad_packet(input string why);
    $display("error: malformed request packet at %0t, %s", $time, why);
    error_o = 1'b1;
    forever @(posedge clk_i);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // packet parser and responder
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    // fill derived from the whole word index
    for (int i = 0; i < 256; i++) begin
      mem[i] = {8{i[7:0]}} ^ 64'h0123_4567_89ab_cdef;
    end
    seed        = SEED;
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_data_o  = '0;
    error_o     = 1'b0;
    forever begin
      take_flit(hdr_flit, last);
      req_hdr  = hdr_flit;
      is_store = (req_hdr.msg_type == NOC_STORE_REQ);
      if (!is_store && req_hdr.msg_type != NOC_LOAD_REQ) begin
        report_bad_packet("unknown request message type");
      end
      if (req_hdr.payload_len != (is_store ? 8'd2 : 8'd1)) begin
        report_bad_packet("wrong payload_len in header");
      end
      if (last) begin
        report_bad_packet("flit after last");
      end
      take_flit(addr_flit, last);
      if (is_store) begin
        if (last) begin
          report_bad_packet("flit after last");
        end
        take_flit(data_flit, last);
      end
      if (!last) begin
        report_bad_packet("missing last on final flit");
      end
      // word select, anything above bit 10 is off the map
      idx = addr_flit[10:3];
      oor = |addr_flit[63:11];
      @(negedge clk_i);
      req_ready_o = 1'b0;
      delay = $random(seed) & 7;
      repeat (delay) @(negedge clk_i);
      rsp_hdr = '0;
      if (is_store) begin
        if (!oor) begin
          for (int b = 0; b < 8; b++) begin
            if (req_hdr.strb[b]) begin
              mem[idx][8*b +: 8] = data_flit[8*b +: 8];
            end
          end
        end
        rsp_hdr.msg_type = oor ? NOC_STORE_NACK : NOC_STORE_ACK;
        give_flit(rsp_hdr);
      end else begin
        rsp_hdr.payload_len = 8'd1;
        rsp_hdr.msg_type    = oor ? NOC_LOAD_NACK : NOC_LOAD_ACK;
        give_flit(rsp_hdr);
        // nack still carries a junk flit
        give_flit(oor ? 64'hbad0_bad0_bad0_bad0 : mem[idx]);
      end
      @(negedge clk_i);
      rsp_valid_o = 1'b0;
    end
  end

endmodule

/* tb_noc_axil_bridge.sv */
`timescale 1ns/1ps
`include "noc_defines.svh"

module tb_noc_axil_bridge;

  localparam logic [31:0] SEED = 32'h769d_4d45;
  // strobe test, same-cycle pair, error test, random run
  localparam int NUM_OPS     = 8 + 2 + 3 + 200;
  localparam int CYCLE_LIMIT = 60 * NUM_OPS + 100;

  logic                        clk_i;
  logic                        reset_l;
  logic                        tile_rst_l_o;
  logic [`AXIL_ADDR_WIDTH-1:0] aw_addr_i;
  logic                        aw_valid_i;
  logic                        aw_ready_o;
  logic [`AXIL_DATA_WIDTH-1:0] w_data_i;
  logic [`AXIL_STRB_WIDTH-1:0] w_strb_i;
  logic                        w_valid_i;
  logic                        w_ready_o;
  logic [1:0]                  b_resp_o;
  logic                        b_valid_o;
  logic                        b_ready_i;
  logic [`AXIL_ADDR_WIDTH-1:0] ar_addr_i;
  logic                        ar_valid_i;
  logic                        ar_ready_o;
  logic [`AXIL_DATA_WIDTH-1:0] r_data_o;
  logic [1:0]                  r_resp_o;
  logic                        r_valid_o;
  logic                        r_ready_i;
  logic                        noc_out_valid_o;
  logic [`NOC_DATA_WIDTH-1:0]  noc_out_data_o;
  logic                        noc_out_last_o;
  logic                        noc_out_ready_i;
  logic                        noc_in_valid_i;
  logic [`NOC_DATA_WIDTH-1:0]  noc_in_data_i;
  logic                        noc_in_ready_o;
  logic                        model_err;

  integer      seed;
  integer      gap_seed;
  int          cycle_cnt = 0;
  int          rd_issued = 0;
  int          rd_done = 0;
  int          wr_issued = 0;
  int          wr_done = 0;
  // {resp, data} per outstanding request
  logic [65:0] rd_expect_q[$];
  logic [65:0] wr_expect_q[$];
  logic [65:0] rd_exp;
  logic [65:0] wr_exp;
  logic [63:0] shadow [0:255];
  logic [7:0]  strb_set [4] = '{8'h0f, 8'h3c, 8'hf0, 8'h81};
  logic [31:0] r;
  logic [39:0] addr;
  logic [63:0] data;
  int          lag;

  noc_axil_bridge_top UUT (.*);

  tb_noc_mem_model #(.SEED(SEED ^ 32'h0000_a5a5)) mem_model (
    .clk_i       (clk_i),
    .req_valid_i (noc_out_valid_o),
    .req_data_i  (noc_out_data_o),
    .req_last_i  (noc_out_last_o),
    .req_ready_o (noc_out_ready_i),
    .rsp_valid_o (noc_in_valid_i),
    .rsp_data_o  (noc_in_data_i),
    .rsp_ready_i (noc_in_ready_o),
    .error_o     (model_err)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model and checking
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  // expected {resp, data}, stores update the shadow copy
  function automatic logic [65:0] predict(input logic is_wr, input logic [39:0] a,
                                          input logic [63:0] wdata, input logic [7:0] strb);
    logic [7:0]  idx;
    logic [63:0] word;
    idx = a[10:3];
    if (|a[39:11]) begin
      return {2'b10, 64'h0};
    end
    if (is_wr) begin
      word = shadow[idx];
      for (int b = 0; b < 8; b++) begin
        if (strb[b]) begin
          word[8*b +: 8] = wdata[8*b +: 8];
        end
      end
      shadow[idx] = word;
      return {2'b00, 64'h0};
    end
    return {2'b00, shadow[idx]};
  endfunction

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, actual, expected);
      abort_run();
    end
  endtask

  // compare every r and b beat against the queued prediction
  always @(posedge clk_i) begin
    if (r_valid_o && r_ready_i) begin
      if (rd_expect_q.size() == 0) begin
        $display("error: read response at %0t with no read outstanding", $time);
        abort_run();
      end else begin
        rd_exp = rd_expect_q.pop_front();
        check_value(r_data_o, rd_exp[63:0], "read data");
        check_value(64'(r_resp_o), 64'(rd_exp[65:64]), "read resp");
        rd_done++;
      end
    end
    if (b_valid_o && b_ready_i) begin
      if (wr_expect_q.size() == 0) begin
        $display("error: write response at %0t with no write outstanding", $time);
        abort_run();
      end else begin
        wr_exp = wr_expect_q.pop_front();
        check_value(64'(b_resp_o), 64'(wr_exp[65:64]), "write resp");
        wr_done++;
      end
    end
  end

  // watchdog, also stops on a packet error from the memory
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (model_err) begin
      abort_run();
    end else if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("error: run did not finish within %0d cycles", CYCLE_LIMIT);
      abort_run();
    end
  end

  // rready and bready gaps
  initial begin
    logic [31:0] g;
    gap_seed  = SEED ^ 32'h0000_ffff;
    r_ready_i = 1'b1;
    b_ready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      g = $random(gap_seed);
      r_ready_i = (g[1:0] != 2'b00);
      b_ready_i = (g[3:2] != 2'b00);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // AXI-lite drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_read(input logic [39:0] a);
    rd_expect_q.push_back(predict(1'b0, a, '0, '0));
    rd_issued++;
    @(negedge clk_i);
    ar_addr_i  = a;
    ar_valid_i = 1'b1;
    do @(posedge clk_i); while (!ar_ready_o);
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  // aw and w each raised after their own lag in cycles
  task automatic run_write(input logic [39:0] a, input logic [63:0] d, input logic [7:0] s,
                           input int aw_lag, input int w_lag);
    logic aw_done;
    logic w_done;
    int   n;
    wr_expect_q.push_back(predict(1'b1, a, d, s));
    wr_issued++;
    aw_done = 1'b0;
    w_done  = 1'b0;
    n       = 0;
    @(negedge clk_i);
    aw_addr_i  = a;
    w_data_i   = d;
    w_strb_i   = s;
    aw_valid_i = (aw_lag == 0);
    w_valid_i  = (w_lag == 0);
    while (!(aw_done && w_done)) begin
      @(posedge clk_i);
      aw_done = aw_done | (aw_valid_i & aw_ready_o);
      w_done  = w_done | (w_valid_i & w_ready_o);
      @(negedge clk_i);
      n++;
      aw_valid_i = !aw_done && (n >= aw_lag);
      w_valid_i  = !w_done && (n >= w_lag);
    end
  endtask

  task automatic wait_quiet();
    while (rd_done != rd_issued || wr_done != wr_issued) @(negedge clk_i);
  endtask

  // in range, or with one random bit above bit 10 set
  function automatic logic [39:0] make_addr(input logic [7:0] idx, input logic oor);
    logic [39:0] a;
    logic [31:0] x;
    x = next_rand();
    a = {29'h0, idx, x[2:0]};
    if (oor) begin
      a = a | (40'h800 << (x[15:8] % 8'd29));
    end
    return a;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed = SEED;
    for (int i = 0; i < 256; i++) begin
      shadow[i] = {8{i[7:0]}} ^ 64'h0123_4567_89ab_cdef;
    end
    reset_l    = 1'b0;
    aw_addr_i  = '0;
    aw_valid_i = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_valid_i  = 1'b0;
    ar_addr_i  = '0;
    ar_valid_i = 1'b0;
    repeat (4) @(negedge clk_i);
    check_value(64'(tile_rst_l_o), 64'h0, "tile reset during reset_l");
    reset_l = 1'b1;

    // tile reset lifts 18 cycles after release, outputs stay idle
    for (int k = 1; k <= 24; k++) begin
      @(negedge clk_i);
      check_value(64'(tile_rst_l_o), 64'(k >= 18), "tile reset release");
      check_value(64'(noc_out_valid_o), 64'h0, "idle noc_out_valid");
      check_value(64'(r_valid_o), 64'h0, "idle r_valid");
      check_value(64'(b_valid_o), 64'h0, "idle b_valid");
    end
    check_value(64'({ar_ready_o, aw_ready_o, w_ready_o}), 64'h7, "idle ready outputs");
    check_value(64'(noc_in_ready_o), 64'h0, "idle noc_in_ready");

    // partial strobes, then read back the merged words
    for (int i = 0; i < 4; i++) begin
      run_write({29'h0, 8'(16 + i), 3'b000}, {8{8'(8'hc0 + i)}}, strb_set[i], 0, i);
    end
    wait_quiet();
    for (int i = 0; i < 4; i++) begin
      run_read({29'h0, 8'(16 + i), 3'b000});
    end
    wait_quiet();

    // read and write in the same cycle
    fork
      run_read({29'h0, 8'd20, 3'b000});
      run_write({29'h0, 8'd21, 3'b000}, 64'h1122_3344_5566_7788, 8'hff, 0, 0);
    join
    wait_quiet();

    // out of range, then show the word untouched
    run_write(40'h800 | {29'h0, 8'd16, 3'b000}, 64'hffff_ffff_ffff_ffff, 8'hff, 0, 0);
    wait_quiet();
    run_read({1'b1, 28'h0, 8'd16, 3'b000});
    wait_quiet();
    run_read({29'h0, 8'd16, 3'b000});
    wait_quiet();

    // random mix with back-pressure everywhere
    for (int op = 0; op < 200; op++) begin
      r    = next_rand();
      addr = make_addr(r[7:0], r[10:8] == 3'b000);
      data = {next_rand(), next_rand()};
      lag  = int'(r[27:26]);
      case (r[31:30])
        2'b00: run_read(addr);
        2'b01: run_write(addr, data, r[23:16], r[28] ? lag : 0, r[28] ? 0 : lag);
        default: begin
          // pair on different words so order does not matter
          fork
            run_read(make_addr(r[7:0] ^ 8'h80, r[11]));
            run_write(addr, data, r[23:16], 0, lag);
          join
        end
      endcase
      wait_quiet();
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

/* tb.f */
+incdir+.
noc_pkg.sv
axil_pkg.sv
noc_flit_if.sv
tile_reset_seq.sv
axil_read_unit.sv
axil_write_unit.sv
noc_port_arbiter.sv
noc_axil_bridge_top.sv
tb_noc_mem_model.sv
tb_noc_axil_bridge.sv

/* run_sim.sh */
#!/bin/sh
# build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_noc_axil_bridge -f tb.f -o tb_sim

./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -qx '>>> PASS' sim.log; then
  exit 0
else
  exit 1
fi
